//--- cmdRegisterTop.f
logic/cmdRegPkg.sv
logic/cmdCreditFifo.sv
logic/cmdDecoder.sv
logic/registerBank.sv
logic/cmdRegisterTop.sv
tb/tbClock.sv
tb/cmdRegisterTop_sva.sv
tb/cmdRegisterTb.sv

//--- logic/cmdCreditFifo.sv
// Credit FIFO
// Stores command beats from the host in a circular buffer and hands them to
// the decoder, which is always ready. Every pop returns one credit to the host
module cmdCreditFifo
#(
    parameter int CMD_WIDTH  = 64,
    parameter int FIFO_DEPTH = 8
)
(
    input  logic                 aclk,
    input  logic                 resetn,
    input  logic                 beatValid,
    input  logic [CMD_WIDTH-1:0] beatData,
    output logic                 creditReturn,
    output logic                 fifoValid,
    output logic [CMD_WIDTH-1:0] fifoBeat
);

    // Pointer width is kept at one bit or more so a depth of one still builds
    localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [CMD_WIDTH-1:0]   fifoMem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wrPtr;
    logic [PTR_WIDTH-1:0]   rdPtr;
    logic [COUNT_WIDTH-1:0] fifoCount;
    logic                   pushBeat;
    logic                   popBeat;

    // Advance a pointer and wrap it at the last slot, depth need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // The host only sends while it holds a credit, so a beat always has room
    assign pushBeat = beatValid;
    // The decoder takes whatever sits at the head
    assign popBeat  = (fifoCount != '0);

    assign fifoValid = popBeat;
    assign fifoBeat  = fifoMem[rdPtr];

    always_ff @(posedge aclk)
    begin
        if (pushBeat)
        begin
            fifoMem[wrPtr] <= beatData;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            fifoCount    <= '0;
            creditReturn <= 1'b0;
        end
        else
        begin
            if (pushBeat)
            begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popBeat)
            begin
                rdPtr <= nextPtr(rdPtr);
            end
            // One credit pulse in the cycle after each pop edge
            creditReturn <= popBeat;
            case ({pushBeat, popBeat})
                2'b10:   fifoCount <= fifoCount + 1'b1;
                2'b01:   fifoCount <= fifoCount - 1'b1;
                default: fifoCount <= fifoCount;
            endcase
        end
    end

endmodule

//--- logic/cmdDecoder.sv
// Command decoder
// Splits the beat stream into headers and WRITE payloads and issues one
// registered bank request per payload beat or COMMIT header
module cmdDecoder
#(
    parameter int CMD_WIDTH = 64
)
(
    input  logic                 aclk,
    input  logic                 resetn,
    input  logic                 fifoValid,
    input  logic [CMD_WIDTH-1:0] fifoBeat,
    output cmdRegPkg::bankReq_t  bankReq,
    output logic [CMD_WIDTH-1:0] bankData,
    output logic                 cmdError
);
    import cmdRegPkg::*;

    // Number of 32-bit registers carried by one payload beat
    localparam int LANES = CMD_WIDTH / REG_WIDTH;

    decState_e  state;
    beatCount_t remainingBeats;
    regOffset_t writeOffset;
    regOffset_t runIndex;

    cmdOpcode_t hdrOpcode;
    beatCount_t hdrCount;
    regOffset_t hdrOffset;

    // Header fields, only meaningful while in DEC_HEADER
    assign hdrOpcode = fifoBeat[31:28];
    assign hdrCount  = fifoBeat[15:8];
    assign hdrOffset = fifoBeat[7:0];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state          <= DEC_HEADER;
            bankReq.write  <= 1'b0;
            bankReq.commit <= 1'b0;
            cmdError       <= 1'b0;
        end
        else
        begin
            // Requests are single-cycle pulses
            bankReq.write  <= 1'b0;
            bankReq.commit <= 1'b0;
            if (fifoValid)
            begin
                case (state)
                    DEC_HEADER:
                    begin
                        case (hdrOpcode)
                            OP_NOP:
                            begin
                            end
                            OP_WRITE:
                            begin
                                // A WRITE of zero beats is a header with nothing behind it
                                if (hdrCount != '0)
                                begin
                                    writeOffset    <= hdrOffset;
                                    remainingBeats <= hdrCount;
                                    runIndex       <= '0;
                                    state          <= DEC_PAYLOAD;
                                end
                            end
                            OP_COMMIT:
                            begin
                                bankReq.commit <= 1'b1;
                            end
                            default:
                            begin
                                // Unknown opcode, skip the beat and keep the flag set
                                cmdError <= 1'b1;
                            end
                        endcase
                    end
                    DEC_PAYLOAD:
                    begin
                        bankReq.write     <= 1'b1;
                        bankReq.baseIndex <= writeOffset + runIndex;
                        bankData          <= fifoBeat;
                        runIndex          <= runIndex + regOffset_t'(LANES);
                        remainingBeats    <= remainingBeats - 1'b1;
                        // Back to headers once the last counted beat is out
                        if (remainingBeats == beatCount_t'(1))
                        begin
                            state <= DEC_HEADER;
                        end
                    end
                    default:
                    begin
                        state <= DEC_HEADER;
                    end
                endcase
            end
        end
    end

endmodule

//--- logic/cmdRegPkg.sv
// Command register package
// Shared widths, header field types, opcodes, decoder states and the
// request word that the decoder hands to the register bank
package cmdRegPkg;

    // Every bank register is one 32-bit word
    localparam int REG_WIDTH = 32;

    // One register value as stored in the staging and active arrays
    typedef logic [REG_WIDTH-1:0] regWord_t;

    // Register offset from header bits 7..0, so the bank holds 256 entries at most
    typedef logic [7:0] regOffset_t;

    // Opcode from header bits 31..28
    typedef logic [3:0] cmdOpcode_t;

    // Payload beat count from header bits 15..8
    typedef logic [7:0] beatCount_t;

    // Opcodes the decoder understands
    // Anything else is skipped as a one-beat command and flagged
    localparam cmdOpcode_t OP_NOP    = 4'd0;
    localparam cmdOpcode_t OP_WRITE  = 4'd1;
    localparam cmdOpcode_t OP_COMMIT = 4'd2;

    // Decoder FSM
    // DEC_HEADER expects a command header on the next popped beat
    // DEC_PAYLOAD consumes the data beats of a WRITE
    typedef enum logic
    {
        DEC_HEADER,
        DEC_PAYLOAD
    } decState_e;

    // Request from the decoder to the bank, valid for a single cycle
    // write and commit are never set together
    typedef struct packed
    {
        logic       write;
        logic       commit;
        // Register index of lane 0, before the bank wraps it
        regOffset_t baseIndex;
    } bankReq_t;

endpackage

//--- logic/cmdRegisterTop.sv
// Command register front end
// Chains the credit FIFO, the command decoder and the double-buffered
// register bank, and sets the parameters of all three
module cmdRegisterTop
#(
    parameter int BANK_SIZE  = 16,
    parameter int CMD_WIDTH  = 64,
    parameter int FIFO_DEPTH = 8
)
(
    input  logic                                        aclk,
    input  logic                                        resetn,
    input  logic                                        beatValid,
    input  logic [CMD_WIDTH-1:0]                        beatData,
    output logic                                        creditReturn,
    output logic [BANK_SIZE*cmdRegPkg::REG_WIDTH-1:0]   registers,
    output logic                                        cmdError
);
    import cmdRegPkg::*;

    logic                 fifoValid;
    logic [CMD_WIDTH-1:0] fifoBeat;
    bankReq_t             bankReq;
    logic [CMD_WIDTH-1:0] bankData;

    // Host beats enter here and leave one cycle after they reach the head
    cmdCreditFifo #(.CMD_WIDTH(CMD_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) cmdCreditFifo_inst
    (
        .aclk         (aclk),
        .resetn       (resetn),
        .beatValid    (beatValid),
        .beatData     (beatData),
        .creditReturn (creditReturn),
        .fifoValid    (fifoValid),
        .fifoBeat     (fifoBeat)
    );

    cmdDecoder #(.CMD_WIDTH(CMD_WIDTH)) cmdDecoder_inst
    (
        .aclk      (aclk),
        .resetn    (resetn),
        .fifoValid (fifoValid),
        .fifoBeat  (fifoBeat),
        .bankReq   (bankReq),
        .bankData  (bankData),
        .cmdError  (cmdError)
    );

    registerBank #(.BANK_SIZE(BANK_SIZE), .CMD_WIDTH(CMD_WIDTH)) registerBank_inst
    (
        .aclk      (aclk),
        .resetn    (resetn),
        .bankReq   (bankReq),
        .bankData  (bankData),
        .registers (registers)
    );

endmodule

//--- logic/registerBank.sv
// Register bank
// Unpacks payload beats into a staging array, lane by lane with index
// wrapping, and copies staging into the active array on a commit
module registerBank
#(
    parameter int BANK_SIZE = 16,
    parameter int CMD_WIDTH = 64
)
(
    input  logic                                        aclk,
    input  logic                                        resetn,
    input  cmdRegPkg::bankReq_t                         bankReq,
    input  logic [CMD_WIDTH-1:0]                        bankData,
    output logic [BANK_SIZE*cmdRegPkg::REG_WIDTH-1:0]   registers
);
    import cmdRegPkg::*;

    localparam int LANES       = CMD_WIDTH / REG_WIDTH;
    localparam int INDEX_WIDTH = (BANK_SIZE > 1) ? $clog2(BANK_SIZE) : 1;

    regWord_t               stagingRegs [BANK_SIZE];
    regWord_t               activeRegs  [BANK_SIZE];
    logic [INDEX_WIDTH-1:0] laneIndex   [LANES];

    // Bank size is a power of two, so dropping the upper bits is the modulo
    always_comb
    begin
        for (int k = 0; k < LANES; k++)
        begin
            laneIndex[k] = INDEX_WIDTH'(bankReq.baseIndex + regOffset_t'(k));
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < BANK_SIZE; i++)
            begin
                stagingRegs[i] <= '0;
                activeRegs[i]  <= '0;
            end
        end
        else
        begin
            if (bankReq.write)
            begin
                // Lane 0 sits in the low word of the beat
                for (int k = 0; k < LANES; k++)
                begin
                    stagingRegs[laneIndex[k]] <= bankData[k*REG_WIDTH +: REG_WIDTH];
                end
            end
            // The rasterizer only ever sees a complete, committed set
            if (bankReq.commit)
            begin
                activeRegs <= stagingRegs;
            end
        end
    end

    // Flatten the active array, register 0 in the low bits
    for (genvar i = 0; i < BANK_SIZE; i++)
    begin : genFlatten
        assign registers[i*REG_WIDTH +: REG_WIDTH] = activeRegs[i];
    end

endmodule

//--- run.sh
#!/bin/sh
# Builds the command register testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cmdRegisterTop.f \
    --top-module cmdRegisterTb -o simCmdRegister
./obj_dir/simCmdRegister | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- tb/bankCases.txt
# Tags: T test name, B beat in hex, W drain, C index and active value in hex, E cmdError
# Header beat: opcode [31:28], beat count [15:8], offset [7:0], lane 0 is the low word
T writeCommit
B 10000202
B AAAA0003AAAA0002
B AAAA0005AAAA0004
B 20000000
W
C 2 AAAA0002
C 3 AAAA0003
C 5 AAAA0005
C 6 00000000
E 0
T stagingHold
B 10000108
B BBBB0009BBBB0008
W
C 8 00000000
C 2 AAAA0002
B 20000000
W
C 8 BBBB0008
C 9 BBBB0009
T wrapAround
B 1000020E
B CCCC000FCCCC000E
B CCCC0001CCCC0000
B 20000000
W
C 14 CCCC000E
C 15 CCCC000F
C 0 CCCC0000
C 1 CCCC0001
T longBurst
B 10000804
B D0000005D0000004
B D0000007D0000006
B D0000009D0000008
B D000000BD000000A
B D000000DD000000C
B D000000FD000000E
B D0000001D0000000
B D0000003D0000002
B 20000000
W
C 4 D0000004
C 15 D000000F
C 3 D0000003
E 0
T badOpcode
B 70000000
B 10000106
B 6666000766660006
B 20000000
W
E 1
C 6 66660006
T nopKeep
B 00000000
B 10000100
B 7777000177770000
B 00000000
B 20000000
W
C 0 77770000
C 7 66660007
E 1

//--- tb/cmdRegisterTb.sv
// Command register testbench
// Replays the beats of tb/bankCases.txt under credit flow control and checks
// the active registers and the error flag against the expected values there
module cmdRegisterTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BANK_SIZE      = 16;
    localparam int CMD_WIDTH      = 64;
    localparam int FIFO_DEPTH     = 8;
    localparam int TIMEOUT_CYCLES = 200;

    logic                    aclk;
    logic                    resetn;
    logic                    beatValid;
    logic [CMD_WIDTH-1:0]    beatData;
    logic                    creditReturn;
    logic [BANK_SIZE*32-1:0] registers;
    logic                    cmdError;

    // Credits the sender holds, refilled by creditReturn pulses
    int credits;
    int errorCount;
    int testErrors;
    int testsRun;
    int testsFailed;
    logic [8*32-1:0] testName;

    tbClock tbClock_inst (.aclk(aclk));

    cmdRegisterTop #(.BANK_SIZE(BANK_SIZE), .CMD_WIDTH(CMD_WIDTH), .FIFO_DEPTH(FIFO_DEPTH))
        cmdRegisterTop_inst
    (
        .aclk         (aclk),
        .resetn       (resetn),
        .beatValid    (beatValid),
        .beatData     (beatData),
        .creditReturn (creditReturn),
        .registers    (registers),
        .cmdError     (cmdError)
    );

    // Move 1 ns past the next rising edge, where the DUT outputs have settled
    // A credit pulse lasts one cycle, so it is counted exactly once here
    task automatic tickCycle();
        @(posedge aclk);
        #1;
        if (creditReturn)
        begin
            credits++;
        end
    endtask

    // Send one beat after 0 to 3 idle cycles, waiting for a credit first
    task automatic sendBeat(input logic [CMD_WIDTH-1:0] beat);
        int idle;
        int waited;
        idle = $urandom % 4;
        waited = 0;
        repeat (idle)
        begin
            tickCycle();
        end
        while (credits == 0)
        begin
            if (waited == TIMEOUT_CYCLES)
            begin
                $display("Timeout: no credit came back from the DUT");
                $display("=== FAIL ===");
                $finish;
            end
            tickCycle();
            waited++;
        end
        beatValid = 1'b1;
        beatData  = beat;
        credits--;
        tickCycle();
        beatValid = 1'b0;
    endtask

    // All credits back means every beat was popped, two more edges let a
    // trailing commit reach the active registers
    task automatic drainPipeline();
        int waited;
        waited = 0;
        while (credits != FIFO_DEPTH)
        begin
            if (waited == TIMEOUT_CYCLES)
            begin
                $display("Timeout: credits did not return while draining the pipeline");
                $display("=== FAIL ===");
                $finish;
            end
            tickCycle();
            waited++;
        end
        repeat (2)
        begin
            tickCycle();
        end
    endtask

    task automatic checkRegister(input int index, input logic [31:0] expected);
        logic [31:0] actual;
        actual = registers[index*32 +: 32];
        if (actual !== expected)
        begin
            $display("[ERROR] registers[%0d] expected 0x%08h actual 0x%08h",
                     index, expected, actual);
            testErrors++;
            errorCount++;
        end
    endtask

    task automatic checkError(input logic expected);
        if (cmdError !== expected)
        begin
            $display("[ERROR] cmdError expected 0x%0h actual 0x%0h", expected, cmdError);
            testErrors++;
            errorCount++;
        end
    endtask

    // Every tagged line must carry all of its fields
    task automatic checkFields(input int code, input int wanted, input logic [7:0] tag);
        if (code != wanted)
        begin
            $display("Line tagged '%c' in the cases file has missing fields", tag);
            testErrors++;
            errorCount++;
        end
    endtask

    // Report the test that just ended, if one was open
    task automatic finishTest();
        if (testName != '0)
        begin
            testsRun++;
            if (testErrors == 0)
            begin
                $display("Test %0s: ok", testName);
            end
            else
            begin
                testsFailed++;
                $display("Test %0s: %0d mismatches", testName, testErrors);
            end
        end
        testErrors = 0;
    endtask

    initial
    begin
        int fd;
        int code;
        int index;
        logic [7:0] tag;
        logic [CMD_WIDTH-1:0] beat;
        logic [31:0] expected;
        logic [8*128-1:0] skipLine;
        resetn = 1'b0;
        beatValid = 1'b0;
        beatData = '0;
        credits = 0;
        errorCount = 0;
        testErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        testName = '0;
        void'($urandom(75790));
        repeat (16)
        begin
            tickCycle();
        end
        resetn = 1'b1;
        credits = FIFO_DEPTH;

        fd = $fopen("tb/bankCases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open tb/bankCases.txt");
            errorCount++;
        end
        // One tag character starts each line, its fields follow
        while (fd != 0 && $fscanf(fd, " %c", tag) == 1)
        begin
            case (tag)
                "#": code = $fgets(skipLine, fd);
                "T":
                begin
                    finishTest();
                    code = $fscanf(fd, " %s", testName);
                    checkFields(code, 1, tag);
                end
                "B":
                begin
                    code = $fscanf(fd, " %h", beat);
                    checkFields(code, 1, tag);
                    sendBeat(beat);
                end
                "W": drainPipeline();
                "C":
                begin
                    code = $fscanf(fd, " %d %h", index, expected);
                    checkFields(code, 2, tag);
                    checkRegister(index, expected);
                end
                "E":
                begin
                    code = $fscanf(fd, " %h", expected);
                    checkFields(code, 1, tag);
                    checkError(expected[0]);
                end
                default:
                begin
                    $display("Unknown line tag '%c' in the cases file", tag);
                    errorCount++;
                end
            endcase
        end
        finishTest();
        if (fd != 0)
        begin
            $fclose(fd);
        end

        $display("Tests run %0d, tests failed %0d, mismatches %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0 && testsRun > 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb/cmdRegisterTop_sva.sv
// Command register protocol checks
// Bound into the top level, watches the credit FIFO, the decoder state and bank writes
module cmdRegisterTop_sva
#(
    parameter int FIFO_DEPTH = 8
)
(
    input logic                                aclk,
    input logic                                resetn,
    input logic                                beatValid,
    input logic                                creditReturn,
    input logic                                fifoValid,
    input logic [$clog2(FIFO_DEPTH + 1)-1:0]   fifoCount,
    input cmdRegPkg::decState_e                decState,
    input cmdRegPkg::bankReq_t                 bankReq
);
    timeunit 1ns;
    timeprecision 100ps;
    import cmdRegPkg::*;

    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Beats the host has sent whose credit has not come back yet
    logic [COUNT_WIDTH-1:0] outstanding;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            outstanding <= '0;
        end
        else
        begin
            outstanding <= outstanding + COUNT_WIDTH'(beatValid) - COUNT_WIDTH'(creditReturn);
        end
    end

    // A sender that holds a credit always finds a free slot
    assert property (@(posedge aclk) disable iff (!resetn)
        beatValid |-> (fifoCount != COUNT_WIDTH'(FIFO_DEPTH)))
        else $error("Beat sent while the FIFO was full");

    // Each credit pulse pays back a beat that was sent and not yet credited
    assert property (@(posedge aclk) disable iff (!resetn)
        creditReturn |-> (outstanding != '0))
        else $error("Credit returned without a matching beat");

    // Bank writes only come from payload beats of a WRITE
    assert property (@(posedge aclk) disable iff (!resetn)
        bankReq.write |-> $past(fifoValid && (decState == DEC_PAYLOAD)))
        else $error("Bank write issued outside a WRITE payload");

endmodule

bind cmdRegisterTop cmdRegisterTop_sva #(.FIFO_DEPTH(FIFO_DEPTH)) cmdRegisterTop_sva_inst
(
    .aclk         (aclk),
    .resetn       (resetn),
    .beatValid    (beatValid),
    .creditReturn (creditReturn),
    .fifoValid    (fifoValid),
    .fifoCount    (cmdCreditFifo_inst.fifoCount),
    .decState     (cmdDecoder_inst.state),
    .bankReq      (bankReq)
);

//--- tb/tbClock.sv
// Testbench clock
// Free-running 10 ns clock for the command register testbench
module tbClock
(
    output logic aclk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        aclk = 1'b0;
    end

    // Half of the 10 ns period
    always #5 aclk = ~aclk;

endmodule
